// ==== src/mesi_bcast_pkg.sv ====
package mesi_bcast_pkg;

  // =========================================================================
  // Coherence bus geometry
  // =========================================================================

  // Four CPUs share one coherence bus
  localparam int N_CPU = 4;
  localparam int CPU_ID_W = 2;
  localparam int ADDR_W = 32;

  // Broadcast request queue sizing
  localparam int FIFO_DEPTH = 4;
  // Pointer wraps naturally at FIFO_DEPTH
  localparam int FIFO_PTR_W = 2;

  // =========================================================================
  // Encodings
  // =========================================================================

  // Per-CPU coherence bus command
  typedef enum logic [2:0]
  {
    cbus_nop      = 3'd0,
    cbus_wr_snoop = 3'd1,
    cbus_rd_snoop = 3'd2,
    cbus_en_wr    = 3'd3,
    cbus_en_rd    = 3'd4
  } cbus_cmd_e;

  // Broadcast request kind
  typedef enum logic [1:0]
  {
    breq_nop = 2'd0,
    breq_wr  = 2'd1,
    breq_rd  = 2'd2
  } breq_type_e;

  // One queued broadcast request, 36 bits
  typedef struct packed
  {
    logic [ADDR_W-1:0]   addr;
    breq_type_e          req_type;
    logic [CPU_ID_W-1:0] cpu_id;
  } bcast_req_t;

endpackage

// ==== src/snoop_state_if.sv ====
`timescale 1ns/1ps

// Sequencer state as seen by the command encoder
interface snoop_state_if;

  // CPUs still owing a snoop acknowledge
  logic [mesi_bcast_pkg::N_CPU-1:0] snoop_mask;
  // Initiator lane, only while the grant is shown
  logic [mesi_bcast_pkg::N_CPU-1:0] grant_mask;
  // Head request fields
  mesi_bcast_pkg::breq_type_e req_type;
  logic [mesi_bcast_pkg::ADDR_W-1:0] req_addr;

  // Sequencer side
  modport master
  (
    output snoop_mask,
    output grant_mask,
    output req_type,
    output req_addr
  );

  // Encoder side
  modport receiver
  (
    input snoop_mask,
    input grant_mask,
    input req_type,
    input req_addr
  );

endinterface

// ==== src/bcast_req_fifo.sv ====
`timescale 1ns/1ps

module bcast_req_fifo
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      wr_i,
  input  mesi_bcast_pkg::bcast_req_t req_i,
  input  logic                      pop_i,
  output logic                      head_valid_o,
  output mesi_bcast_pkg::bcast_req_t head_req_o,
  output logic                      full_o
);

  // Request storage
  mesi_bcast_pkg::bcast_req_t mem [mesi_bcast_pkg::FIFO_DEPTH];

  logic [mesi_bcast_pkg::FIFO_PTR_W-1:0] wr_ptr;
  logic [mesi_bcast_pkg::FIFO_PTR_W-1:0] rd_ptr;
  logic [mesi_bcast_pkg::FIFO_PTR_W-1:0] rd_ptr_nxt;
  // Used entries, reads 0 both when empty and when full
  logic [mesi_bcast_pkg::FIFO_PTR_W-1:0] depth;
  logic empty;
  logic full;
  logic depth_inc;
  logic depth_dec;

  assign rd_ptr_nxt = rd_ptr + 1'b1;
  assign depth = wr_ptr - rd_ptr;

  // Net change in occupancy
  assign depth_inc = wr_i & ~pop_i;
  assign depth_dec = pop_i & ~wr_i;

  // =========================================================================
  // Write side
  // =========================================================================

  always_ff @(posedge clk)
  begin
    if (wr_i)
    begin
      mem[wr_ptr] <= req_i;
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
    end
    else if (wr_i)
    begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  // =========================================================================
  // Read side
  // =========================================================================

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      rd_ptr <= '0;
    end
    else if (pop_i)
    begin
      rd_ptr <= rd_ptr_nxt;
    end
  end

  // Registered head, always holds entry at rd_ptr
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      head_req_o <= '0;
    end
    // Empty, or last entry leaving: the incoming write lands at the head
    else if (empty || (pop_i && depth == mesi_bcast_pkg::FIFO_PTR_W'(1)))
    begin
      head_req_o <= req_i;
    end
    else if (pop_i)
    begin
      head_req_o <= mem[rd_ptr_nxt];
    end
    else
    begin
      head_req_o <= mem[rd_ptr];
    end
  end

  // =========================================================================
  // Status flags
  // =========================================================================

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      empty <= 1'b1;
    end
    // Last entry popped with no refill
    else if (depth == mesi_bcast_pkg::FIFO_PTR_W'(1) && depth_dec)
    begin
      empty <= 1'b1;
    end
    else if (depth_inc)
    begin
      empty <= 1'b0;
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      full <= 1'b0;
    end
    // Last free slot taken
    else if (depth == mesi_bcast_pkg::FIFO_PTR_W'(mesi_bcast_pkg::FIFO_DEPTH - 1) && depth_inc)
    begin
      full <= 1'b1;
    end
    else if (depth_dec)
    begin
      full <= 1'b0;
    end
  end

  assign head_valid_o = ~empty;
  assign full_o = full;

endmodule

// ==== src/bcast_sequencer.sv ====
`timescale 1ns/1ps

module bcast_sequencer
(
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             head_valid_i,
  input  mesi_bcast_pkg::bcast_req_t       head_req_i,
  input  logic [mesi_bcast_pkg::N_CPU-1:0] ack_i,
  output logic                             pop_o,
  snoop_state_if.master                    snoop
);

  // A request is being served, snoop through pop
  logic in_progress;
  // Snoops not yet acknowledged
  logic [mesi_bcast_pkg::N_CPU-1:0] snoop_mask;
  // Initiator lane for the grant phase
  logic [mesi_bcast_pkg::N_CPU-1:0] init_mask;
  // Head initiator as one-hot
  logic [mesi_bcast_pkg::N_CPU-1:0] init_oh;

  assign init_oh = {{(mesi_bcast_pkg::N_CPU-1){1'b0}}, 1'b1} << head_req_i.cpu_id;

  // =========================================================================
  // Request sequencing
  // =========================================================================
  // Start: snoop all but the initiator, remember the initiator
  // Snoop: drop each CPU on its ack
  // Grant: hold enable on initiator until its ack, then pop
  // Pop: one cycle, then back to idle
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      in_progress <= 1'b0;
      snoop_mask  <= '0;
      init_mask   <= '0;
      pop_o       <= 1'b0;
    end
    else if (!in_progress)
    begin
      if (head_valid_i)
      begin
        in_progress <= 1'b1;
        snoop_mask  <= ~init_oh;
        init_mask   <= init_oh;
      end
    end
    else if (|snoop_mask)
    begin
      // Acks on lanes not snooped are ignored
      snoop_mask <= snoop_mask & ~ack_i;
    end
    else if (pop_o)
    begin
      // Request retired
      in_progress <= 1'b0;
      init_mask   <= '0;
      pop_o       <= 1'b0;
    end
    else
    begin
      // Grant phase, wait for initiator ack
      pop_o <= |(init_mask & ack_i);
    end
  end

  // =========================================================================
  // Encoder view
  // =========================================================================

  assign snoop.snoop_mask = snoop_mask;
  // Grant only once snoops are done, and never in the pop cycle
  assign snoop.grant_mask = (snoop_mask == '0 && !pop_o) ? init_mask : '0;
  assign snoop.req_type = head_req_i.req_type;
  assign snoop.req_addr = head_req_i.addr;

endmodule

// ==== src/cbus_cmd_encoder.sv ====
`timescale 1ns/1ps

module cbus_cmd_encoder
(
  snoop_state_if.receiver                   snoop,
  output mesi_bcast_pkg::cbus_cmd_e         cbus_cmd_o [mesi_bcast_pkg::N_CPU],
  output logic [mesi_bcast_pkg::ADDR_W-1:0] cbus_addr_o
);

  // Write request, else treated as read
  logic is_wr;

  assign is_wr = (snoop.req_type == mesi_bcast_pkg::breq_wr);

  // =========================================================================
  // Per-lane command
  // =========================================================================
  // Snoop wins over grant; masks never overlap anyway
  always_comb
  begin
    for (int i = 0; i < mesi_bcast_pkg::N_CPU; i++)
    begin
      if (snoop.snoop_mask[i])
      begin
        cbus_cmd_o[i] = is_wr ? mesi_bcast_pkg::cbus_wr_snoop : mesi_bcast_pkg::cbus_rd_snoop;
      end
      else if (snoop.grant_mask[i])
      begin
        cbus_cmd_o[i] = is_wr ? mesi_bcast_pkg::cbus_en_wr : mesi_bcast_pkg::cbus_en_rd;
      end
      else
      begin
        cbus_cmd_o[i] = mesi_bcast_pkg::cbus_nop;
      end
    end
  end

  // Shared address for all lanes
  assign cbus_addr_o = snoop.req_addr;

endmodule

// ==== src/mesi_bcast_top.sv ====
`timescale 1ns/1ps

module mesi_bcast_top
(
  input  logic                                clk,
  input  logic                                rst,
  // Request write port
  input  logic                                breq_wr_i,
  input  logic [mesi_bcast_pkg::ADDR_W-1:0]   breq_addr_i,
  input  mesi_bcast_pkg::breq_type_e          breq_type_i,
  input  logic [mesi_bcast_pkg::CPU_ID_W-1:0] breq_cpu_id_i,
  // Coherence bus
  input  logic [mesi_bcast_pkg::N_CPU-1:0]    cbus_ack_i,
  output logic [mesi_bcast_pkg::ADDR_W-1:0]   cbus_addr_o,
  output mesi_bcast_pkg::cbus_cmd_e           cbus_cmd_o [mesi_bcast_pkg::N_CPU],
  output logic                                fifo_full_o
);

  mesi_bcast_pkg::bcast_req_t req;
  mesi_bcast_pkg::bcast_req_t head_req;
  logic head_valid;
  logic pop;

  snoop_state_if snoop_if ();

  // Pack incoming fields
  assign req = '{addr: breq_addr_i, req_type: breq_type_i, cpu_id: breq_cpu_id_i};

  // Input side, request queue
  bcast_req_fifo u_fifo
  (
    .clk          (clk),
    .rst          (rst),
    .wr_i         (breq_wr_i),
    .req_i        (req),
    .pop_i        (pop),
    .head_valid_o (head_valid),
    .head_req_o   (head_req),
    .full_o       (fifo_full_o)
  );

  // Snoop then grant, one request at a time
  bcast_sequencer u_seq
  (
    .clk          (clk),
    .rst          (rst),
    .head_valid_i (head_valid),
    .head_req_i   (head_req),
    .ack_i        (cbus_ack_i),
    .pop_o        (pop),
    .snoop        (snoop_if.master)
  );

  // Output side, lane commands
  cbus_cmd_encoder u_enc
  (
    .snoop        (snoop_if.receiver),
    .cbus_cmd_o   (cbus_cmd_o),
    .cbus_addr_o  (cbus_addr_o)
  );

endmodule

// ==== bench/mesi_bcast_props.sv ====
`timescale 1ns/1ps

module mesi_bcast_props
(
  input logic                      clk,
  input logic                      rst,
  input logic                      wr_i,
  input logic                      pop_i,
  input logic                      head_valid_i,
  input logic                      full_i,
  input mesi_bcast_pkg::cbus_cmd_e cmd_i [mesi_bcast_pkg::N_CPU]
);

  // Count of failed checks
  int fail_count = 0;
  // Lanes showing en_wr or en_rd
  logic [mesi_bcast_pkg::N_CPU-1:0] en_lanes;

  always_comb
  begin
    for (int i = 0; i < mesi_bcast_pkg::N_CPU; i++)
    begin
      en_lanes[i] = (cmd_i[i] == mesi_bcast_pkg::cbus_en_wr) ||
                    (cmd_i[i] == mesi_bcast_pkg::cbus_en_rd);
    end
  end

  // ==========================================================================
  // Queue and bus sanity
  // ==========================================================================

  // Writer honours the full flag
  no_wr_when_full: assert property (@(posedge clk) disable iff (rst) full_i |-> !wr_i)
  else
  begin
    $error("Request written while the queue is full");
    fail_count++;
  end

  // Sequencer only retires a real head
  no_pop_when_empty: assert property (@(posedge clk) disable iff (rst) !head_valid_i |-> !pop_i)
  else
  begin
    $error("Pop issued while the queue is empty");
    fail_count++;
  end

  // Only the initiator of the current request is granted
  one_enable: assert property (@(posedge clk) disable iff (rst) $onehot0(en_lanes))
  else
  begin
    $error("More than one lane carries an enable command");
    fail_count++;
  end

endmodule

// Top level sees queue, sequencer and bus signals together
bind mesi_bcast_top mesi_bcast_props u_props
(
  .clk          (clk),
  .rst          (rst),
  .wr_i         (breq_wr_i),
  .pop_i        (pop),
  .head_valid_i (head_valid),
  .full_i       (fifo_full_o),
  .cmd_i        (cbus_cmd_o)
);

// ==== bench/tb_mesi_bcast.sv ====
`timescale 1ns/1ps

module tb_mesi_bcast;

  localparam int N_REQ = 40;
  // 40 cycles per request plus slack
  localparam int MAX_CYCLES = N_REQ * 40 + 200;

  logic clk;
  logic rst;
  logic breq_wr;
  logic [mesi_bcast_pkg::ADDR_W-1:0] breq_addr;
  mesi_bcast_pkg::breq_type_e breq_type;
  logic [mesi_bcast_pkg::CPU_ID_W-1:0] breq_cpu_id;
  logic [mesi_bcast_pkg::N_CPU-1:0] cbus_ack;
  logic [mesi_bcast_pkg::ADDR_W-1:0] cbus_addr;
  mesi_bcast_pkg::cbus_cmd_e cbus_cmd [mesi_bcast_pkg::N_CPU];
  logic fifo_full;

  // Reference model state with the request in service at the head of ref_q
  mesi_bcast_pkg::bcast_req_t ref_q [$];
  bit ref_busy = 1'b0;
  bit [mesi_bcast_pkg::N_CPU-1:0] ref_snoop = '0;
  bit ref_pop = 1'b0;

  // Stimulus state
  logic [31:0] lfsr;
  bit ack_hold;
  int hold_cnt;
  int gap;
  int n_sent;
  int cycles = 0;
  logic [1:0] ack_wait [mesi_bcast_pkg::N_CPU];

  mesi_bcast_top u_dut
  (
    .clk           (clk),
    .rst           (rst),
    .breq_wr_i     (breq_wr),
    .breq_addr_i   (breq_addr),
    .breq_type_i   (breq_type),
    .breq_cpu_id_i (breq_cpu_id),
    .cbus_ack_i    (cbus_ack),
    .cbus_addr_o   (cbus_addr),
    .cbus_cmd_o    (cbus_cmd),
    .fifo_full_o   (fifo_full)
  );

  always #50 clk = ~clk;

  // Galois LFSR on x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return val;
  endfunction

  // Expected lane command from the reference state
  function automatic mesi_bcast_pkg::cbus_cmd_e expected_cmd(input int lane);
    mesi_bcast_pkg::cbus_cmd_e cmd;
    logic is_wr;
    cmd = mesi_bcast_pkg::cbus_nop;
    if (ref_busy)
    begin
      is_wr = (ref_q[0].req_type == mesi_bcast_pkg::breq_wr);
      if (ref_snoop[lane])
      begin
        cmd = is_wr ? mesi_bcast_pkg::cbus_wr_snoop : mesi_bcast_pkg::cbus_rd_snoop;
      end
      // Grant after the last snoop ack and gone in the pop cycle
      else if (ref_snoop == '0 && !ref_pop && lane == int'(ref_q[0].cpu_id))
      begin
        cmd = is_wr ? mesi_bcast_pkg::cbus_en_wr : mesi_bcast_pkg::cbus_en_rd;
      end
    end
    return cmd;
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
      $display("Error: %0d ns, %s: got %0h, expected %0h", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  // CPU ack models and the request writer for one falling edge
  task automatic drive_cycle();
    breq_wr = 1'b0;
    for (int i = 0; i < mesi_bcast_pkg::N_CPU; i++)
    begin
      // Idle lane draws a fresh 0..3 cycle ack delay
      if (cbus_cmd[i] == mesi_bcast_pkg::cbus_nop)
      begin
        cbus_ack[i] = 1'b0;
        ack_wait[i] = 2'(take_bits(2));
      end
      else if (!ack_hold && ack_wait[i] != 2'd0)
      begin
        ack_wait[i] = ack_wait[i] - 2'd1;
      end
      else if (!ack_hold)
      begin
        cbus_ack[i] = 1'b1;
      end
    end
    // Let the queue sit full for a while before releasing the acks
    if (ack_hold && ref_q.size() == mesi_bcast_pkg::FIFO_DEPTH)
    begin
      hold_cnt++;
      ack_hold = (hold_cnt < 8);
    end
    if (gap > 0)
    begin
      gap--;
    end
    else if (n_sent < N_REQ && ref_q.size() < mesi_bcast_pkg::FIFO_DEPTH)
    begin
      breq_wr = 1'b1;
      breq_addr = take_bits(32);
      breq_type = take_bits(1) ? mesi_bcast_pkg::breq_rd : mesi_bcast_pkg::breq_wr;
      breq_cpu_id = 2'(take_bits(2));
      n_sent++;
      // Back to back while filling and random gaps after
      gap = ack_hold ? 0 : int'(take_bits(3));
    end
  endtask

  // ==========================================================================
  // Reference model stepped on the same edges as the DUT
  // ==========================================================================
  always @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      ref_q.delete();
      ref_busy = 1'b0;
      ref_snoop = '0;
      ref_pop = 1'b0;
    end
    else
    begin
      if (!ref_busy)
      begin
        // Start on a present head and snoop all but the initiator
        if (ref_q.size() != 0)
        begin
          ref_busy = 1'b1;
          ref_snoop = '1;
          ref_snoop[ref_q[0].cpu_id] = 1'b0;
        end
      end
      else if (ref_snoop != '0)
      begin
        ref_snoop = ref_snoop & ~cbus_ack;
      end
      else if (ref_pop)
      begin
        void'(ref_q.pop_front());
        ref_busy = 1'b0;
        ref_pop = 1'b0;
      end
      else if (cbus_ack[ref_q[0].cpu_id])
      begin
        ref_pop = 1'b1;
      end
      if (breq_wr)
      begin
        ref_q.push_back('{addr: breq_addr, req_type: breq_type, cpu_id: breq_cpu_id});
      end
    end
  end

  // ==========================================================================
  // Monitor comparing every lane each cycle
  // ==========================================================================
  always @(negedge clk)
  begin
    cycles++;
    if (cycles > MAX_CYCLES)
    begin
      $display("TEST FAILED");
      $fatal(1, "Timeout, %0d requests were not served within %0d cycles", N_REQ, MAX_CYCLES);
    end
    else if (u_dut.u_props.fail_count != 0)
    begin
      $display("TEST FAILED");
      $fatal(1, "A bound assertion on the queue or bus failed");
    end
    else
    begin
      for (int i = 0; i < mesi_bcast_pkg::N_CPU; i++)
      begin
        check_eq(32'(cbus_cmd[i]), 32'(expected_cmd(i)), $sformatf("lane %0d command", i));
      end
      if (ref_q.size() != 0)
      begin
        check_eq(cbus_addr, ref_q[0].addr, "bus address");
      end
      check_eq(32'(fifo_full), 32'(ref_q.size() == mesi_bcast_pkg::FIFO_DEPTH), "fifo full");
    end
  end

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    breq_wr = 1'b0;
    breq_addr = '0;
    breq_type = mesi_bcast_pkg::breq_nop;
    breq_cpu_id = '0;
    cbus_ack = '0;
    lfsr = 32'hb935e64f;
    ack_hold = 1'b1;
    hold_cnt = 0;
    gap = 0;
    n_sent = 0;
    ack_wait = '{default: 2'd0};
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // Run until every request has been written and retired
    while (!(n_sent == N_REQ && ref_q.size() == 0 && !ref_busy))
    begin
      @(negedge clk);
      drive_cycle();
    end
    repeat (3) @(negedge clk);
    // Last monitor compare of this edge settles first
    #10;
    if (u_dut.u_props.fail_count != 0)
    begin
      $display("TEST FAILED");
      $fatal(1, "A bound assertion on the queue or bus failed");
    end
    else
    begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

// ==== files.f ====
src/mesi_bcast_pkg.sv
src/snoop_state_if.sv
src/bcast_req_fifo.sv
src/bcast_sequencer.sv
src/cbus_cmd_encoder.sv
src/mesi_bcast_top.sv
bench/mesi_bcast_props.sv
bench/tb_mesi_bcast.sv

// ==== Makefile ====
# Verilator flow for the MESI broadcast unit

VERILATOR ?= verilator
TOP       ?= tb_mesi_bcast
FILELIST  ?= files.f
MDIR      ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Build and run; exit status is the test result
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)
	./$(MDIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(MDIR)
